// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_sap3_controller
LOG       ?= sim.log
FILELIST  ?= sap3_controller.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv include/*.svh testbench/*.sv)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	$(SIM) > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hdl/exec_microcode.sv ====
`timescale 1ns/1ps

module exec_microcode #(
	parameter int STAGE_W = 4
) (
	input  logic [STAGE_W-1:0]   stage,
	input  sap3_pkg::decoded_t   dec,
	output sap3_pkg::ctrl_word_t exec_word,
	output logic                 last
);
	import sap3_pkg::*;

	localparam logic [STAGE_W-1:0] ST3 = STAGE_W'(3);
	localparam logic [STAGE_W-1:0] ST4 = STAGE_W'(4);
	localparam logic [STAGE_W-1:0] ST5 = STAGE_W'(5);
	localparam logic [STAGE_W-1:0] ST6 = STAGE_W'(6);
	localparam logic [STAGE_W-1:0] ST7 = STAGE_W'(7);
	localparam logic [STAGE_W-1:0] ST8 = STAGE_W'(8);

	alu_op_t op_set0;
	alu_op_t op_set1;
	alu_op_t op_step;

	assign op_set0 = alu_op_t'({2'b00, dec.dst});
	assign op_set1 = alu_op_t'({2'b01, dec.dst});
	assign op_step = dec.dec ? ALU_DCR : ALU_INR;

	// source field onto the bus, A drives through the ALU
	function automatic ctrl_word_t with_read(ctrl_word_t w, logic [2:0] f);
		ctrl_word_t r;
		r = w;
		if (f == ACC_FIELD) begin
			r.alu_oe = 1'b1;
		end else begin
			r.reg_rd_sel = reg_sel_t'({2'b00, f});
			r.reg_oe = 1'b1;
		end
		return r;
	endfunction

	function automatic ctrl_word_t with_write(ctrl_word_t w, logic [2:0] f);
		ctrl_word_t r;
		r = w;
		if (f == ACC_FIELD) begin
			r.alu_a_we = 1'b1;
		end else begin
			r.reg_wr_sel = reg_sel_t'({2'b00, f});
			r.reg_we = 1'b1;
		end
		return r;
	endfunction

	function automatic ctrl_word_t with_pc_mar(ctrl_word_t w);
		ctrl_word_t r;
		r = w;
		r.reg_rd_sel = REG_PC;
		r.reg_oe = 1'b1;
		r.mem_mar_we = 1'b1;
		return r;
	endfunction

	function automatic ctrl_word_t with_pc_ext(ctrl_word_t w, reg_ext_t ext);
		ctrl_word_t r;
		r = w;
		r.reg_wr_sel = REG_PC;
		r.reg_ext = ext;
		return r;
	endfunction

	always_comb begin
		exec_word = '0;
		last = 1'b0;

		case (dec.iclass)
			IC_NOP: begin
				last = (stage == ST3);
			end
			IC_HLT: begin
				// no last, the counter runs out by wrapping
				exec_word.hlt = (stage == ST3);
			end
			IC_OUT: begin
				if (stage == ST3) begin
					exec_word = with_pc_ext(exec_word, EXT_INC);
					exec_word.display = 1'b1;
					last = 1'b1;
				end
			end
			IC_MOV: begin
				if (stage == ST3) begin
					exec_word = with_read(exec_word, dec.src);
					exec_word = with_write(exec_word, dec.dst);
					last = 1'b1;
				end
			end
			IC_MVI: begin
				case (stage)
					ST3: exec_word = with_pc_mar(exec_word);
					ST4: begin
						exec_word = with_write(exec_word, dec.dst);
						exec_word.mem_oe = 1'b1;
					end
					ST5: begin
						exec_word = with_pc_ext(exec_word, EXT_INC);
						last = 1'b1;
					end
					default: ;
				endcase
			end
			IC_ALU_REG: begin
				if (stage == ST3) begin
					exec_word.alu_tmp_we = 1'b1;
					if (dec.src == ACC_FIELD) begin
						exec_word.alu_cs = 1'b1;
						exec_word.alu_op = op_set0;
						last = 1'b1;
					end else begin
						exec_word = with_read(exec_word, dec.src);
					end
				end else if (stage == ST4) begin
					exec_word.alu_cs = 1'b1;
					exec_word.alu_op = op_set0;
					last = 1'b1;
				end
			end
			IC_ALU_ACC: begin
				if (stage == ST3) begin
					exec_word.alu_cs = 1'b1;
					exec_word.alu_op = op_set1;
					last = 1'b1;
				end
			end
			IC_ALU_IMM: begin
				case (stage)
					ST3: exec_word = with_pc_mar(exec_word);
					ST4: begin
						exec_word.mem_oe = 1'b1;
						exec_word.alu_tmp_we = 1'b1;
					end
					ST5: begin
						exec_word = with_pc_ext(exec_word, EXT_INC);
						exec_word.alu_cs = 1'b1;
						exec_word.alu_op = op_set0;
						last = 1'b1;
					end
					default: ;
				endcase
			end
			IC_INR_DCR: begin
				if (dec.dst == ACC_FIELD) begin
					exec_word.alu_cs = (stage == ST3);
					exec_word.alu_op = (stage == ST3) ? op_step : ALU_ADD;
					last = (stage == ST3);
				end else begin
					// park A, step the operand in A, then put A back
					case (stage)
						ST3: begin
							exec_word = with_read(exec_word, dec.dst);
							exec_word.alu_a_store = 1'b1;
							exec_word.alu_a_we = 1'b1;
						end
						ST4: begin
							exec_word.alu_cs = 1'b1;
							exec_word.alu_op = op_step;
						end
						ST5: begin
							exec_word = with_write(exec_word, dec.dst);
							exec_word.alu_oe = 1'b1;
							exec_word.alu_a_restore = 1'b1;
							last = 1'b1;
						end
						default: ;
					endcase
				end
			end
			IC_JMP, IC_JCOND: begin
				if (dec.iclass == IC_JCOND && !dec.take && stage == ST3) begin
					// skip both address bytes
					exec_word = with_pc_ext(exec_word, EXT_INC2);
					last = 1'b1;
				end else begin
					case (stage)
						ST3, ST6: exec_word = with_pc_mar(exec_word);
						ST4, ST7: begin
							exec_word.reg_wr_sel = (stage == ST4) ? REG_Z : REG_W;
							exec_word.reg_we = 1'b1;
							exec_word.mem_oe = 1'b1;
						end
						ST5: exec_word = with_pc_ext(exec_word, EXT_INC);
						ST8: begin
							exec_word.reg_rd_sel = REG_WZ;
							exec_word.reg_oe = 1'b1;
							exec_word.reg_wr_sel = REG_PC;
							exec_word.reg_we = 1'b1;
							last = 1'b1;
						end
						default: ;
					endcase
				end
			end
			default: ;
		endcase

		// two drivers on the data bus
		assert (!(exec_word.reg_oe && exec_word.alu_oe));
	end

endmodule

// ==== hdl/opcode_decoder.sv ====
`timescale 1ns/1ps

module opcode_decoder (
	input  logic [7:0]         opcode,
	input  logic [3:0]         flags,
	output sap3_pkg::decoded_t dec
);
	import sap3_pkg::*;

	always_comb begin
		dec.dst = opcode[5:3];
		dec.src = opcode[2:0];
		dec.dec = opcode[0];
		// bits 5..4 pick the flag, bit 3 the level it must have
		dec.take = (flags[opcode[5:4]] == opcode[3]);

		casez (opcode)
			8'o000: begin
				dec.iclass = IC_NOP;
			end
			8'o166: begin
				dec.iclass = IC_HLT;
			end
			// memory operand forms, ahead of their register groups
			8'o1?6, 8'o16?, 8'o064, 8'o065, 8'o2?6, 8'o066: begin
				dec.iclass = IC_UNDEF;
			end
			8'o1??: begin
				dec.iclass = IC_MOV;
			end
			8'o0?4, 8'o0?5: begin
				dec.iclass = IC_INR_DCR;
			end
			8'o2??: begin
				dec.iclass = IC_ALU_REG;
			end
			8'o0?7: begin
				dec.iclass = IC_ALU_ACC;
			end
			8'o3?6: begin
				dec.iclass = IC_ALU_IMM;
			end
			8'o0?6: begin
				dec.iclass = IC_MVI;
			end
			8'o303: begin
				dec.iclass = IC_JMP;
			end
			8'o3?2: begin
				dec.iclass = IC_JCOND;
			end
			8'o323: begin
				dec.iclass = IC_OUT;
			end
			default: begin
				// 16-bit, stack and unassigned codes
				dec.iclass = IC_UNDEF;
			end
		endcase
	end

endmodule

// ==== hdl/sap3_controller.sv ====
`timescale 1ns/1ps

module sap3_controller #(
	parameter int STAGE_W = 4
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [7:0]           opcode,
	input  logic [3:0]           flags,
	output sap3_pkg::ctrl_word_t ctrl
);
	import sap3_pkg::*;

	decoded_t           dec;
	logic [STAGE_W-1:0] stage;
	ctrl_word_t         exec_word;
	logic               last;

	opcode_decoder u_opcode_decoder (
		.opcode (opcode),
		.flags  (flags),
		.dec    (dec)
	);

	exec_microcode #(
		.STAGE_W (STAGE_W)
	) u_exec_microcode (
		.stage     (stage),
		.dec       (dec),
		.exec_word (exec_word),
		.last      (last)
	);

	stage_sequencer #(
		.STAGE_W (STAGE_W)
	) u_stage_sequencer (
		.clk       (clk),
		.rst       (rst),
		.exec_word (exec_word),
		.last      (last),
		.stage     (stage),
		.ctrl      (ctrl)
	);

endmodule

// ==== hdl/sap3_pkg.sv ====
package sap3_pkg;

	// register file selectors, pairs have bit 4 set
	typedef enum logic [4:0] {
		REG_B  = 5'd0,
		REG_C  = 5'd1,
		REG_D  = 5'd2,
		REG_E  = 5'd3,
		REG_H  = 5'd4,
		REG_L  = 5'd5,
		REG_W  = 5'd6,
		REG_Z  = 5'd7,
		REG_HL = 5'd20,
		REG_WZ = 5'd22,
		REG_PC = 5'd24
	} reg_sel_t;

	// 16-bit extension op on the selected write pair
	typedef enum logic [1:0] {
		EXT_NONE = 2'd0,
		EXT_INC  = 2'd1,
		EXT_INC2 = 2'd3
	} reg_ext_t;

	typedef enum logic [4:0] {
		ALU_ADD = 5'd0,
		ALU_ADC = 5'd1,
		ALU_SUB = 5'd2,
		ALU_SBB = 5'd3,
		ALU_ANA = 5'd4,
		ALU_XRA = 5'd5,
		ALU_ORA = 5'd6,
		ALU_CMP = 5'd7,
		// set 1, accumulator only
		ALU_RLC = 5'd8,
		ALU_RRC = 5'd9,
		ALU_RAL = 5'd10,
		ALU_RAR = 5'd11,
		ALU_DAA = 5'd12,
		ALU_CMA = 5'd13,
		ALU_STC = 5'd14,
		ALU_CMC = 5'd15,
		ALU_INR = 5'd16,
		ALU_DCR = 5'd17
	} alu_op_t;

	typedef struct packed {
		logic     display;
		logic     hlt;
		logic     alu_cs;
		logic     alu_a_we;
		logic     alu_a_store;
		logic     alu_a_restore;
		logic     alu_tmp_we;
		alu_op_t  alu_op;
		logic     alu_oe;
		reg_sel_t reg_rd_sel;
		reg_sel_t reg_wr_sel;
		reg_ext_t reg_ext;
		logic     reg_oe;
		logic     reg_we;
		logic     mem_we;
		logic     mem_mar_we;
		logic     mem_oe;
		logic     ir_we;
	} ctrl_word_t;

	typedef enum logic [3:0] {
		IC_NOP,
		IC_HLT,
		IC_OUT,
		IC_MOV,
		IC_MVI,
		IC_ALU_REG,
		IC_ALU_ACC,
		IC_ALU_IMM,
		IC_INR_DCR,
		IC_JMP,
		IC_JCOND,
		IC_UNDEF
	} instr_class_t;

	typedef struct packed {
		instr_class_t iclass;
		logic [2:0]   dst;
		logic [2:0]   src;
		logic         take;
		logic         dec;
	} decoded_t;

	// register field that names the accumulator
	localparam logic [2:0] ACC_FIELD = 3'd7;

endpackage

// ==== hdl/stage_sequencer.sv ====
`timescale 1ns/1ps

module stage_sequencer #(
	parameter int STAGE_W = 4
) (
	input  logic                 clk,
	input  logic                 rst,
	input  sap3_pkg::ctrl_word_t exec_word,
	input  logic                 last,
	output logic [STAGE_W-1:0]   stage,
	output sap3_pkg::ctrl_word_t ctrl
);
	import sap3_pkg::*;

	localparam logic [STAGE_W-1:0] ST_MAR  = STAGE_W'(0);
	localparam logic [STAGE_W-1:0] ST_IR   = STAGE_W'(1);
	localparam logic [STAGE_W-1:0] ST_INC  = STAGE_W'(2);
	localparam logic [STAGE_W-1:0] ST_EXEC = STAGE_W'(3);

	logic in_exec;

	assign in_exec = (stage >= ST_EXEC);

	always_ff @(posedge clk) begin
		if (rst) begin
			stage <= '0;
		end else if (in_exec && last) begin
			stage <= '0;
		end else begin
			stage <= stage + 1'b1;
		end
	end

	always_comb begin
		ctrl = '0;
		case (stage)
			ST_MAR: begin
				ctrl.reg_rd_sel = REG_PC;
				ctrl.reg_oe = 1'b1;
				ctrl.mem_mar_we = 1'b1;
			end
			ST_IR: begin
				ctrl.mem_oe = 1'b1;
				ctrl.ir_we = 1'b1;
			end
			ST_INC: begin
				ctrl.reg_wr_sel = REG_PC;
				ctrl.reg_ext = EXT_INC;
			end
			default: ctrl = exec_word;
		endcase
	end

	a_ir_load_in_fetch: assert property (@(posedge clk) disable iff (rst)
		ctrl.ir_we |-> stage == ST_IR);

	a_last_restarts_fetch: assert property (@(posedge clk) disable iff (rst)
		last |=> stage == ST_MAR);

endmodule

// ==== sap3_controller.f ====
+incdir+include
hdl/sap3_pkg.sv
hdl/opcode_decoder.sv
hdl/exec_microcode.sv
hdl/stage_sequencer.sv
hdl/sap3_controller.sv
testbench/tb_sap3_controller.sv

// ==== include/tb_checks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// fetch words by stage, stage 0 doubles as the MAR from PC word
function automatic ctrl_word_t fetch_word(int n);
	ctrl_word_t w;
	w = '0;
	case (n)
		0: begin
			w.reg_rd_sel = REG_PC;
			w.reg_oe = 1'b1;
			w.mem_mar_we = 1'b1;
		end
		1: begin
			w.mem_oe = 1'b1;
			w.ir_we = 1'b1;
		end
		default: begin
			w.reg_wr_sel = REG_PC;
			w.reg_ext = EXT_INC;
		end
	endcase
	return w;
endfunction

// register field without M
function automatic logic [2:0] pick_reg();
	logic [2:0] r;
	r = 3'($urandom % 7);
	if (r == 3'd6) begin
		r = ACC_FIELD;
	end
	return r;
endfunction

function automatic logic [3:0] rand_flags();
	return 4'($urandom);
endfunction

task automatic clear_expected();
	for (int i = 0; i < WRAP_CYCLES; i++) begin
		exp_words[i] = '0;
	end
endtask

task automatic check_field(string field, logic [31:0] want, logic [31:0] got);
	if (got !== want) begin
		$display("MISMATCH at time %0t: %s stage %0d %s expected %0h actual %0h",
			$time, cur_name, cur_stage, field, want, got);
		errors++;
	end
endtask

task automatic compare_word(ctrl_word_t want, int s);
	cur_stage = s;
	check_field("display", 32'(want.display), 32'(ctrl.display));
	check_field("hlt", 32'(want.hlt), 32'(ctrl.hlt));
	check_field("alu_cs", 32'(want.alu_cs), 32'(ctrl.alu_cs));
	check_field("alu_a_we", 32'(want.alu_a_we), 32'(ctrl.alu_a_we));
	check_field("alu_a_store", 32'(want.alu_a_store), 32'(ctrl.alu_a_store));
	check_field("alu_a_restore", 32'(want.alu_a_restore), 32'(ctrl.alu_a_restore));
	check_field("alu_tmp_we", 32'(want.alu_tmp_we), 32'(ctrl.alu_tmp_we));
	check_field("alu_op", 32'(want.alu_op), 32'(ctrl.alu_op));
	check_field("alu_oe", 32'(want.alu_oe), 32'(ctrl.alu_oe));
	check_field("reg_rd_sel", 32'(want.reg_rd_sel), 32'(ctrl.reg_rd_sel));
	check_field("reg_wr_sel", 32'(want.reg_wr_sel), 32'(ctrl.reg_wr_sel));
	check_field("reg_ext", 32'(want.reg_ext), 32'(ctrl.reg_ext));
	check_field("reg_oe", 32'(want.reg_oe), 32'(ctrl.reg_oe));
	check_field("reg_we", 32'(want.reg_we), 32'(ctrl.reg_we));
	check_field("mem_we", 32'(want.mem_we), 32'(ctrl.mem_we));
	check_field("mem_mar_we", 32'(want.mem_mar_we), 32'(ctrl.mem_mar_we));
	check_field("mem_oe", 32'(want.mem_oe), 32'(ctrl.mem_oe));
	check_field("ir_we", 32'(want.ir_we), 32'(ctrl.ir_we));
endtask

// sampled mid-cycle, stage 0 must be showing
task automatic check_fetch_start();
	@(negedge clk);
	if (ctrl !== fetch_word(0)) begin
		$display("at time %0t the fetch word did not come back after %s", $time, cur_name);
		errors++;
	end
endtask

task automatic run_instr(string name, logic [7:0] op, logic [3:0] fl, int len);
	check_fetch_start();
	cur_name = name;
	@(posedge clk);
	#DRIVE_DELAY;
	opcode = op;
	flags = fl;
	for (int s = 1; s < len; s++) begin
		@(negedge clk);
		compare_word((s < 3) ? fetch_word(s) : exp_words[s], s);
		@(posedge clk);
		#DRIVE_DELAY;
	end
endtask

task automatic test_nop();
	clear_expected();
	run_instr("NOP", 8'o000, rand_flags(), 4);
endtask

task automatic test_mov(logic [2:0] d, logic [2:0] s);
	clear_expected();
	if (s == ACC_FIELD) begin
		exp_words[3].alu_oe = 1'b1;
	end else begin
		exp_words[3].reg_rd_sel = reg_sel_t'({2'b00, s});
		exp_words[3].reg_oe = 1'b1;
	end
	if (d == ACC_FIELD) begin
		exp_words[3].alu_a_we = 1'b1;
	end else begin
		exp_words[3].reg_wr_sel = reg_sel_t'({2'b00, d});
		exp_words[3].reg_we = 1'b1;
	end
	run_instr($sformatf("MOV %0d,%0d", d, s), {2'b01, d, s}, rand_flags(), 4);
endtask

task automatic test_mvi();
	logic [2:0] d;
	d = pick_reg();
	clear_expected();
	exp_words[3] = fetch_word(0);
	exp_words[4].mem_oe = 1'b1;
	if (d == ACC_FIELD) begin
		exp_words[4].alu_a_we = 1'b1;
	end else begin
		exp_words[4].reg_wr_sel = reg_sel_t'({2'b00, d});
		exp_words[4].reg_we = 1'b1;
	end
	exp_words[5] = fetch_word(2);
	run_instr($sformatf("MVI %0d", d), {2'b00, d, 3'b110}, rand_flags(), 6);
endtask

task automatic test_alu_reg(logic [2:0] op, logic [2:0] s);
	int len;
	clear_expected();
	exp_words[3].alu_tmp_we = 1'b1;
	if (s == ACC_FIELD) begin
		// A is already on the ALU input
		exp_words[3].alu_cs = 1'b1;
		exp_words[3].alu_op = alu_op_t'({2'b00, op});
		len = 4;
	end else begin
		exp_words[3].reg_rd_sel = reg_sel_t'({2'b00, s});
		exp_words[3].reg_oe = 1'b1;
		exp_words[4].alu_cs = 1'b1;
		exp_words[4].alu_op = alu_op_t'({2'b00, op});
		len = 5;
	end
	run_instr($sformatf("ALU %0d reg %0d", op, s), {2'b10, op, s}, rand_flags(), len);
endtask

task automatic test_alu_acc(logic [2:0] op);
	clear_expected();
	exp_words[3].alu_cs = 1'b1;
	exp_words[3].alu_op = alu_op_t'(5'(8 + op));
	run_instr($sformatf("ALU set 1 op %0d", op), {2'b00, op, 3'b111}, rand_flags(), 4);
endtask

task automatic test_alu_imm(logic [2:0] op);
	clear_expected();
	exp_words[3] = fetch_word(0);
	exp_words[4].mem_oe = 1'b1;
	exp_words[4].alu_tmp_we = 1'b1;
	exp_words[5] = fetch_word(2);
	exp_words[5].alu_cs = 1'b1;
	exp_words[5].alu_op = alu_op_t'({2'b00, op});
	run_instr($sformatf("ALU imm op %0d", op), {2'b11, op, 3'b110}, rand_flags(), 6);
endtask

task automatic test_inr_dcr(logic [2:0] d, logic dcr);
	alu_op_t step;
	int len;
	step = dcr ? ALU_DCR : ALU_INR;
	clear_expected();
	if (d == ACC_FIELD) begin
		exp_words[3].alu_cs = 1'b1;
		exp_words[3].alu_op = step;
		len = 4;
	end else begin
		exp_words[3].reg_rd_sel = reg_sel_t'({2'b00, d});
		exp_words[3].reg_oe = 1'b1;
		exp_words[3].alu_a_store = 1'b1;
		exp_words[3].alu_a_we = 1'b1;
		exp_words[4].alu_cs = 1'b1;
		exp_words[4].alu_op = step;
		exp_words[5].reg_wr_sel = reg_sel_t'({2'b00, d});
		exp_words[5].reg_we = 1'b1;
		exp_words[5].alu_oe = 1'b1;
		exp_words[5].alu_a_restore = 1'b1;
		len = 6;
	end
	run_instr($sformatf("INR/DCR %0d dec %0d", d, dcr), {2'b00, d, 2'b10, dcr},
		rand_flags(), len);
endtask

// address low byte to Z, high byte to W, then PC from WZ
task automatic fill_jump_words();
	exp_words[3] = fetch_word(0);
	exp_words[4].reg_wr_sel = REG_Z;
	exp_words[4].reg_we = 1'b1;
	exp_words[4].mem_oe = 1'b1;
	exp_words[5] = fetch_word(2);
	exp_words[6] = fetch_word(0);
	exp_words[7].reg_wr_sel = REG_W;
	exp_words[7].reg_we = 1'b1;
	exp_words[7].mem_oe = 1'b1;
	exp_words[8].reg_rd_sel = REG_WZ;
	exp_words[8].reg_oe = 1'b1;
	exp_words[8].reg_wr_sel = REG_PC;
	exp_words[8].reg_we = 1'b1;
endtask

task automatic test_jmp();
	clear_expected();
	fill_jump_words();
	run_instr("JMP", 8'o303, rand_flags(), 9);
endtask

task automatic test_jcond(logic [2:0] c);
	logic [3:0] fl;
	logic take;
	int len;
	fl = rand_flags();
	take = (fl[c[2:1]] == c[0]);
	clear_expected();
	if (take) begin
		fill_jump_words();
		len = 9;
	end else begin
		exp_words[3].reg_wr_sel = REG_PC;
		exp_words[3].reg_ext = EXT_INC2;
		len = 4;
	end
	run_instr($sformatf("JCOND %0d flags %h", c, fl), {2'b11, c, 3'b010}, fl, len);
endtask

task automatic test_out();
	clear_expected();
	exp_words[3] = fetch_word(2);
	exp_words[3].display = 1'b1;
	run_instr("OUT", 8'o323, rand_flags(), 4);
endtask

task automatic test_hlt();
	clear_expected();
	exp_words[3].hlt = 1'b1;
	run_instr("HLT", 8'o166, rand_flags(), WRAP_CYCLES);
endtask

task automatic test_undef(logic [7:0] op);
	clear_expected();
	run_instr($sformatf("undefined %o", op), op, rand_flags(), WRAP_CYCLES);
endtask

`endif

// ==== testbench/tb_sap3_controller.sv ====
`timescale 1ns/1ps

module tb_sap3_controller;
	import sap3_pkg::*;

	localparam int STAGE_W = 4;
	localparam int WRAP_CYCLES = 1 << STAGE_W;
	localparam int CLK_PERIOD = 40;
	localparam int DRIVE_DELAY = 2;

	// worst case per test, jumps counted as taken
	localparam int TEST_CYCLES = 2 + 4 + 5 * 4 + 2 * 6 + 8 * 5 + 4 + 8 * 4 + 2 * 6
		+ (6 + 6 + 4 + 4) + 9 + 8 * 9 + 4 + WRAP_CYCLES + WRAP_CYCLES + 1;

	logic       clk = 1'b0;
	logic       rst;
	logic [7:0] opcode;
	logic [3:0] flags;
	ctrl_word_t ctrl;

	ctrl_word_t exp_words[WRAP_CYCLES];
	string      cur_name = "reset";
	int         cur_stage = 0;
	int         errors = 0;

	sap3_controller #(
		.STAGE_W (STAGE_W)
	) u_sap3_controller (
		.clk    (clk),
		.rst    (rst),
		.opcode (opcode),
		.flags  (flags),
		.ctrl   (ctrl)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	`include "tb_checks.svh"

	initial begin
		#((TEST_CYCLES + 100) * CLK_PERIOD);
		$display("timeout, test sequence still running after %0d cycles",
			TEST_CYCLES + 100);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		void'($urandom(32'h7548));
		rst = 1'b1;
		opcode = '0;
		flags = '0;
		repeat (2) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;

		test_nop();
		repeat (4) test_mov(pick_reg(), pick_reg());
		// accumulator on both sides
		test_mov(ACC_FIELD, ACC_FIELD);
		repeat (2) test_mvi();
		for (int i = 0; i < 8; i++) begin
			test_alu_reg(3'(i), pick_reg());
		end
		// short form with A as the source
		test_alu_reg(3'd5, ACC_FIELD);
		for (int i = 0; i < 8; i++) begin
			test_alu_acc(3'(i));
		end
		test_alu_imm(3'd0);
		test_alu_imm(3'd7);
		test_inr_dcr(3'd0, 1'b0);
		test_inr_dcr(3'd0, 1'b1);
		test_inr_dcr(ACC_FIELD, 1'b0);
		test_inr_dcr(ACC_FIELD, 1'b1);
		test_jmp();
		for (int i = 0; i < 8; i++) begin
			test_jcond(3'(i));
		end
		test_out();
		test_hlt();
		// MOV with an M source
		test_undef(8'o106);
		check_fetch_start();

		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule
